// File: sources.f
hw/fetch_pkg.sv
hw/csr_pkg.sv
hw/pc_gen.sv
hw/fetch_queue.sv
hw/fetch_unit.sv
hw/frontend.sv
tb/frontend_checker.sv
tb/tb_frontend.sv

// File: tb/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend
    import fetch_pkg::*;
    import csr_pkg::*;
();

    localparam int NUM_TESTS        = 24;
    localparam int FETCHES_PER_TEST = 6;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic [31:0] target_pc;
    logic        csr_da;
    logic [31:0] csr_dmw0;
    logic [31:0] csr_dmw1;
    plv_e        csr_plv;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat;
    logic        wb_ack;
    logic        ibuf_stall;
    logic        out_valid;
    logic [31:0] out_pc;
    logic [31:0] out_instr0;
    logic [31:0] out_instr1;
    fetch_excp_e out_excp;

    int          test_num;
    logic        done;
    int          consumed;
    int          errors;
    logic        timeout;
    int          seed;
    logic        req_busy;
    int          wait_left;

    frontend #(
        .FTQ_DEPTH(4),
        .RESET_PC (32'h1c00_0000)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush),
        .target_pc_i (target_pc),
        .csr_da_i    (csr_da),
        .csr_dmw0_i  (csr_dmw0),
        .csr_dmw1_i  (csr_dmw1),
        .csr_plv_i   (csr_plv),
        .wb_cyc_o    (wb_cyc),
        .wb_stb_o    (wb_stb),
        .wb_we_o     (wb_we),
        .wb_adr_o    (wb_adr),
        .wb_sel_o    (wb_sel),
        .wb_dat_i    (wb_dat),
        .wb_ack_i    (wb_ack),
        .ibuf_stall_i(ibuf_stall),
        .out_valid_o (out_valid),
        .out_pc_o    (out_pc),
        .out_instr0_o(out_instr0),
        .out_instr1_o(out_instr1),
        .out_excp_o  (out_excp)
    );

    frontend_checker #(
        .NUM_TESTS       (NUM_TESTS),
        .FETCHES_PER_TEST(FETCHES_PER_TEST)
    ) u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush),
        .target_pc_i (target_pc),
        .csr_da_i    (csr_da),
        .csr_dmw0_i  (csr_dmw0),
        .csr_dmw1_i  (csr_dmw1),
        .csr_plv_i   (csr_plv),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .wb_we_i     (wb_we),
        .wb_adr_i    (wb_adr),
        .wb_sel_i    (wb_sel),
        .wb_ack_i    (wb_ack),
        .ibuf_stall_i(ibuf_stall),
        .out_valid_i (out_valid),
        .out_pc_i    (out_pc),
        .out_instr0_i(out_instr0),
        .out_instr1_i(out_instr1),
        .out_excp_i  (out_excp),
        .test_num_i  (test_num),
        .done_i      (done),
        .consumed_o  (consumed),
        .errors_o    (errors),
        .timeout_o   (timeout)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Instruction memory contents, a pure function of the word address
    function automatic logic [31:0] memory_word(input logic [31:0] adr);
        return {adr[31:2], 2'b11} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] make_window(
        input logic [2:0] vseg,
        input logic [2:0] pseg,
        input logic       plv0,
        input logic       plv3
    );
        logic [31:0] dmw;
        dmw = '0;
        dmw[DMW_VSEG_LSB +: 3] = vseg;
        dmw[DMW_PSEG_LSB +: 3] = pseg;
        dmw[DMW_PLV0_BIT]      = plv0;
        dmw[DMW_PLV3_BIT]      = plv3;
        return dmw;
    endfunction

    // Wishbone slave with 0 to 3 wait cycles per single read
    always @(posedge clk) begin
        #5;
        if (!rst_n) begin
            wb_ack   = 1'b0;
            req_busy = 1'b0;
        end else if (wb_ack) begin
            wb_ack   = 1'b0;
            req_busy = 1'b0;
        end else if (wb_stb) begin
            if (!req_busy) begin
                req_busy  = 1'b1;
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                wb_ack = 1'b1;
                wb_dat = memory_word(wb_adr);
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
        flush      = 1'b0;
        ibuf_stall = ($urandom_range(99, 0) < 30);
    endtask

    task automatic wait_packets(input int target);
        while (consumed < target) begin
            next_cycle();
        end
    endtask

    // Redirect with a new CSR setting, held for one cycle
    task automatic apply_flush();
        int          csr_case;
        logic [2:0]  vseg;
        logic [2:0]  pseg;
        logic [31:0] target;
        csr_case    = $urandom_range(4, 0);
        vseg        = $urandom_range(7, 0);
        pseg        = $urandom_range(7, 0);
        target      = $urandom;
        target[31:29] = vseg;
        target[1:0] = 2'b00;
        csr_da      = 1'b0;
        csr_dmw0    = '0;
        csr_dmw1    = '0;
        csr_plv     = PLV_KERNEL;
        case (csr_case)
            0: csr_da = 1'b1;
            1: csr_dmw0 = make_window(vseg, pseg, 1'b1, 1'b0);
            2: begin
                // DMW0 matches too but only for kernel level
                csr_plv  = PLV_USER;
                csr_dmw0 = make_window(vseg, pseg, 1'b1, 1'b0);
                csr_dmw1 = make_window(vseg, ~pseg, 1'b0, 1'b1);
            end
            3: csr_dmw0 = make_window(vseg, pseg, 1'b0, 1'b1);
            default: begin
                csr_plv  = PLV_USER;
                csr_dmw0 = make_window(vseg ^ 3'd1, pseg, 1'b1, 1'b1);
                csr_dmw1 = make_window(vseg ^ 3'd2, pseg, 1'b1, 1'b1);
            end
        endcase
        if ($urandom_range(5, 0) == 0) begin
            target[1:0] = $urandom_range(3, 1);
        end
        target_pc = target;
        flush     = 1'b1;
    endtask

    initial begin
        seed       = $urandom(85969);
        rst_n      = 1'b0;
        flush      = 1'b0;
        target_pc  = '0;
        csr_da     = 1'b1;
        csr_dmw0   = '0;
        csr_dmw1   = '0;
        csr_plv    = PLV_KERNEL;
        wb_ack     = 1'b0;
        wb_dat     = '0;
        req_busy   = 1'b0;
        wait_left  = 0;
        ibuf_stall = 1'b0;
        test_num   = 0;
        done       = 1'b0;
        repeat (4) @(posedge clk);
        #5;
        rst_n = 1'b1;
        // First test runs straight from the reset PC in direct mode
        wait_packets(FETCHES_PER_TEST);
        for (int t = 1; t < NUM_TESTS; t++) begin
            repeat ($urandom_range(7, 0)) next_cycle();
            next_cycle();
            apply_flush();
            test_num = t;
            wait_packets(consumed + FETCHES_PER_TEST);
        end
        next_cycle();
        done = 1'b1;
        @(posedge clk);
        #1;
        if (errors == 0 && !timeout) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        wait (timeout === 1'b1);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: tb/frontend_checker.sv
`timescale 1ns/1ps

module frontend_checker
    import fetch_pkg::*;
    import csr_pkg::*;
#(
    parameter int NUM_TESTS        = 24,
    parameter int FETCHES_PER_TEST = 6
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush_i,
    input  logic [31:0] target_pc_i,
    input  logic        csr_da_i,
    input  logic [31:0] csr_dmw0_i,
    input  logic [31:0] csr_dmw1_i,
    input  plv_e        csr_plv_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [31:0] wb_adr_i,
    input  logic [3:0]  wb_sel_i,
    input  logic        wb_ack_i,
    input  logic        ibuf_stall_i,
    input  logic        out_valid_i,
    input  logic [31:0] out_pc_i,
    input  logic [31:0] out_instr0_i,
    input  logic [31:0] out_instr1_i,
    input  fetch_excp_e out_excp_i,
    input  int          test_num_i,
    input  logic        done_i,
    output int          consumed_o,
    output int          errors_o,
    output logic        timeout_o
);

    localparam logic [31:0] BOOT_PC     = 32'h1c00_0000;
    localparam int          CYCLE_LIMIT = NUM_TESTS * FETCHES_PER_TEST * 60;

    // Model state
    logic [31:0] exp_pc;
    logic        exp_da;
    logic [31:0] exp_dmw0;
    logic [31:0] exp_dmw1;
    plv_e        exp_plv;

    // Bus history since the last consumed packet
    int          acks_since;
    logic        stale_ok;
    logic [31:0] last_adr;
    logic [31:0] prev_adr;
    logic        stb_waiting;
    logic [31:0] stb_adr;
    logic        ack_seen;

    // Stalled packet snapshot
    logic        hold_pending;
    logic [31:0] held_pc;
    logic [31:0] held_instr0;
    logic [31:0] held_instr1;
    fetch_excp_e held_excp;

    int          cycles;
    int          cur_test;
    int          test_pkts;
    int          test_err_base;
    logic        closed;

    initial begin
        consumed_o = 0;
        errors_o   = 0;
        timeout_o  = 1'b0;
        closed     = 1'b0;
    end

    function automatic logic [31:0] expected_word(input logic [31:0] adr);
        return {adr[31:2], 2'b11} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic window_hit(
        input logic [31:0] dmw,
        input plv_e        plv,
        input logic [31:0] va
    );
        logic enabled;
        enabled = (plv == PLV_KERNEL) ? dmw[DMW_PLV0_BIT] : dmw[DMW_PLV3_BIT];
        return enabled && (dmw[DMW_VSEG_LSB +: 3] == va[31:29]);
    endfunction

    task automatic report_mismatch(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        $display("** Error %s: expected %h, got %h at %0t", name, expected, actual, $time);
        errors_o++;
    endtask

    task automatic report_fault(input string what);
        $display("Failure at %0t: %s", $time, what);
        errors_o++;
    endtask

    // Alignment first, then direct mode, DMW0, DMW1
    task automatic translate(
        input  logic [31:0] va,
        output logic [31:0] pa,
        output fetch_excp_e excp
    );
        pa   = va;
        excp = EXCP_NONE;
        if (va[1:0] != 2'b00) begin
            excp = EXCP_ADEF;
        end else if (exp_da) begin
            pa = va;
        end else if (window_hit(exp_dmw0, exp_plv, va)) begin
            pa = {exp_dmw0[DMW_PSEG_LSB +: 3], va[28:0]};
        end else if (window_hit(exp_dmw1, exp_plv, va)) begin
            pa = {exp_dmw1[DMW_PSEG_LSB +: 3], va[28:0]};
        end else begin
            excp = EXCP_NOMAP;
        end
    endtask

    task automatic check_bus();
        if (wb_we_i) report_mismatch("wb_we_o", 32'h0, wb_we_i);
        if (wb_sel_i != 4'hf) report_mismatch("wb_sel_o", 32'hf, wb_sel_i);
        if (wb_stb_i && !wb_cyc_i) report_fault("Wishbone stb high without cyc");
        if (stb_waiting) begin
            if (!wb_stb_i) begin
                report_fault("Wishbone stb dropped before ack");
            end else if (wb_adr_i != stb_adr) begin
                report_mismatch("wb_adr_o", stb_adr, wb_adr_i);
            end
        end
        if (ack_seen && wb_cyc_i) report_fault("Wishbone cyc stayed high after a read");
        if (wb_stb_i && wb_ack_i) begin
            acks_since++;
            prev_adr = last_adr;
            last_adr = wb_adr_i;
        end
        stb_waiting = wb_stb_i && !wb_ack_i;
        stb_adr     = wb_adr_i;
        ack_seen    = wb_cyc_i && wb_ack_i;
    endtask

    task automatic check_hold();
        if (hold_pending) begin
            if (!out_valid_i) begin
                report_fault("packet withdrawn while the instruction buffer stalled");
            end else begin
                if (out_pc_i != held_pc) report_mismatch("out_pc_o", held_pc, out_pc_i);
                if (out_instr0_i != held_instr0) begin
                    report_mismatch("out_instr0_o", held_instr0, out_instr0_i);
                end
                if (out_instr1_i != held_instr1) begin
                    report_mismatch("out_instr1_o", held_instr1, out_instr1_i);
                end
                if (out_excp_i != held_excp) report_mismatch("out_excp_o", held_excp, out_excp_i);
            end
        end
        hold_pending = out_valid_i && ibuf_stall_i && !flush_i;
        held_pc      = out_pc_i;
        held_instr0  = out_instr0_i;
        held_instr1  = out_instr1_i;
        held_excp    = out_excp_i;
    endtask

    task automatic check_packet();
        logic [31:0] pa;
        fetch_excp_e excp;
        int          want;
        translate(exp_pc, pa, excp);
        want = (excp == EXCP_NONE) ? 2 : 0;
        if (out_pc_i != exp_pc) report_mismatch("out_pc_o", exp_pc, out_pc_i);
        if (out_excp_i != excp) report_mismatch("out_excp_o", excp, out_excp_i);
        if (excp == EXCP_NONE) begin
            if (out_instr0_i != expected_word(pa)) begin
                report_mismatch("out_instr0_o", expected_word(pa), out_instr0_i);
            end
            if (out_instr1_i != expected_word(pa + 32'd4)) begin
                report_mismatch("out_instr1_o", expected_word(pa + 32'd4), out_instr1_i);
            end
            if (prev_adr != pa) report_mismatch("wb_adr_o", pa, prev_adr);
            if (last_adr != pa + 32'd4) report_mismatch("wb_adr_o", pa + 32'd4, last_adr);
        end else begin
            if (out_instr0_i != '0) report_mismatch("out_instr0_o", 32'h0, out_instr0_i);
            if (out_instr1_i != '0) report_mismatch("out_instr1_o", 32'h0, out_instr1_i);
        end
        // One read of the flushed stream may still complete
        if (acks_since != want && !(stale_ok && acks_since == want + 1)) begin
            report_fault($sformatf("%0d acknowledged reads before packet %h, expected %0d",
                                   acks_since, exp_pc, want));
        end
        exp_pc     = exp_pc + 32'd8;
        acks_since = 0;
        stale_ok   = 1'b0;
        consumed_o++;
        test_pkts++;
    endtask

    task automatic print_test_line();
        $display("test %0d: %0d packets checked, %0d errors",
                 cur_test, test_pkts, errors_o - test_err_base);
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_pc        = BOOT_PC;
            exp_da        = csr_da_i;
            exp_dmw0      = csr_dmw0_i;
            exp_dmw1      = csr_dmw1_i;
            exp_plv       = csr_plv_i;
            acks_since    = 0;
            stale_ok      = 1'b0;
            stb_waiting   = 1'b0;
            ack_seen      = 1'b0;
            hold_pending  = 1'b0;
            cycles        = 0;
            cur_test      = 0;
            test_pkts     = 0;
            test_err_base = errors_o;
            if (wb_cyc_i || wb_stb_i || out_valid_i) begin
                report_fault("bus cycle or packet valid during reset");
            end
        end else begin
            cycles++;
            check_bus();
            check_hold();
            if (flush_i) begin
                exp_pc     = target_pc_i;
                exp_da     = csr_da_i;
                exp_dmw0   = csr_dmw0_i;
                exp_dmw1   = csr_dmw1_i;
                exp_plv    = csr_plv_i;
                acks_since = 0;
                stale_ok   = 1'b1;
            end else if (out_valid_i && !ibuf_stall_i) begin
                check_packet();
            end
            if (test_num_i != cur_test) begin
                print_test_line();
                cur_test      = test_num_i;
                test_pkts     = 0;
                test_err_base = errors_o;
            end
            if (done_i && !closed) begin
                print_test_line();
                $display("%0d tests, %0d packets checked, %0d errors",
                         cur_test + 1, consumed_o, errors_o);
                closed = 1'b1;
            end
            if (cycles >= CYCLE_LIMIT && !timeout_o) begin
                $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
                timeout_o = 1'b1;
            end
        end
    end

endmodule

// File: hw/frontend.sv
`timescale 1ns/1ps

module frontend
    import fetch_pkg::*;
    import csr_pkg::*;
#(
    parameter int          FTQ_DEPTH = 4,
    parameter logic [31:0] RESET_PC  = DEFAULT_RESET_PC
) (
    input  logic        clk,
    input  logic        rst_n,

    // Backend redirect and CSR state
    input  logic        flush_i,
    input  logic [31:0] target_pc_i,
    input  logic        csr_da_i,
    input  logic [31:0] csr_dmw0_i,
    input  logic [31:0] csr_dmw1_i,
    input  plv_e        csr_plv_i,

    // Wishbone classic master
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    output logic [31:0] wb_adr_o,
    output logic [3:0]  wb_sel_o,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack_i,

    // Instruction buffer
    input  logic        ibuf_stall_i,
    output logic        out_valid_o,
    output logic [31:0] out_pc_o,
    output logic [31:0] out_instr0_o,
    output logic [31:0] out_instr1_o,
    output fetch_excp_e out_excp_o
);

    logic        push;
    logic [31:0] push_va;
    logic [31:0] push_pa;
    fetch_excp_e push_excp;
    logic        ftq_full;
    logic        pop;
    logic        head_valid;
    logic [31:0] head_va;
    logic [31:0] head_pa;
    fetch_excp_e head_excp;

    pc_gen #(
        .RESET_PC(RESET_PC)
    ) u_pc_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush_i    (flush_i),
        .target_pc_i(target_pc_i),
        .csr_da_i   (csr_da_i),
        .csr_dmw0_i (csr_dmw0_i),
        .csr_dmw1_i (csr_dmw1_i),
        .csr_plv_i  (csr_plv_i),
        .full_i     (ftq_full),
        .push_o     (push),
        .push_va_o  (push_va),
        .push_pa_o  (push_pa),
        .push_excp_o(push_excp)
    );

    fetch_queue #(
        .FTQ_DEPTH(FTQ_DEPTH)
    ) u_fetch_queue (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .push_i      (push),
        .push_va_i   (push_va),
        .push_pa_i   (push_pa),
        .push_excp_i (push_excp),
        .pop_i       (pop),
        .full_o      (ftq_full),
        .head_valid_o(head_valid),
        .head_va_o   (head_va),
        .head_pa_o   (head_pa),
        .head_excp_o (head_excp)
    );

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .head_valid_i(head_valid),
        .head_va_i   (head_va),
        .head_pa_i   (head_pa),
        .head_excp_i (head_excp),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .ibuf_stall_i(ibuf_stall_i),
        .pop_o       (pop),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_we_o     (wb_we_o),
        .wb_adr_o    (wb_adr_o),
        .wb_sel_o    (wb_sel_o),
        .out_valid_o (out_valid_o),
        .out_pc_o    (out_pc_o),
        .out_instr0_o(out_instr0_o),
        .out_instr1_o(out_instr1_o),
        .out_excp_o  (out_excp_o)
    );

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush_i,
    input  logic        head_valid_i,
    input  logic [31:0] head_va_i,
    input  logic [31:0] head_pa_i,
    input  fetch_excp_e head_excp_i,
    input  logic [31:0] wb_dat_i,
    input  logic        wb_ack_i,
    input  logic        ibuf_stall_i,
    output logic        pop_o,
    output logic        wb_cyc_o,
    output logic        wb_stb_o,
    output logic        wb_we_o,
    output logic [31:0] wb_adr_o,
    output logic [3:0]  wb_sel_o,
    output logic        out_valid_o,
    output logic [31:0] out_pc_o,
    output logic [31:0] out_instr0_o,
    output logic [31:0] out_instr1_o,
    output fetch_excp_e out_excp_o
);

    localparam logic [31:0] WORD_BYTES = BLOCK_BYTES / FETCH_WORDS;

    typedef enum logic [2:0] {
        IDLE,
        READ0,
        GAP,
        READ1,
        HOLD
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic        discard_q;
    logic        drop;
    logic [31:0] cur_va_q;
    logic [31:0] cur_pa_q;
    logic [31:0] instr0_q;

    // Rest of the current fetch is thrown away
    assign drop = flush_i || discard_q;

    always_comb begin
        state_d = state_q;
        pop_o   = 1'b0;
        case (state_q)
            IDLE: begin
                // Packet register is always empty here
                if (!flush_i && head_valid_i) begin
                    pop_o   = 1'b1;
                    state_d = (head_excp_i == EXCP_NONE) ? READ0 : HOLD;
                end
            end
            READ0: begin
                if (wb_ack_i) begin
                    state_d = drop ? IDLE : GAP;
                end
            end
            GAP: begin
                state_d = flush_i ? IDLE : READ1;
            end
            READ1: begin
                if (wb_ack_i) begin
                    state_d = drop ? IDLE : HOLD;
                end
            end
            HOLD: begin
                if (flush_i || !ibuf_stall_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            discard_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Classic cycles run to their ack, so remember the flush until then
            if (state_d == IDLE) begin
                discard_q <= 1'b0;
            end else if (flush_i) begin
                discard_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            cur_va_q <= head_va_i;
            cur_pa_q <= head_pa_i;
        end
        if (state_q == READ0 && wb_ack_i) begin
            instr0_q <= wb_dat_i;
        end
        if (pop_o && head_excp_i != EXCP_NONE) begin
            // Faulting block gives an empty packet, no bus access
            out_pc_o     <= head_va_i;
            out_instr0_o <= '0;
            out_instr1_o <= '0;
            out_excp_o   <= head_excp_i;
        end else if (state_q == READ1 && wb_ack_i && !drop) begin
            out_pc_o     <= cur_va_q;
            out_instr0_o <= instr0_q;
            out_instr1_o <= wb_dat_i;
            out_excp_o   <= EXCP_NONE;
        end
    end

    assign out_valid_o = (state_q == HOLD);

    // One single read per READ state and cyc low in GAP
    assign wb_cyc_o = (state_q == READ0) || (state_q == READ1);
    assign wb_stb_o = wb_cyc_o;
    assign wb_we_o  = 1'b0;
    assign wb_sel_o = 4'hf;
    assign wb_adr_o = (state_q == READ1) ? cur_pa_q + WORD_BYTES : cur_pa_q;

    a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o));

    // Stalled packet must not change under the instruction buffer
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o && ibuf_stall_i && !flush_i |=>
            out_valid_o && $stable(out_pc_o) && $stable(out_instr0_o) &&
            $stable(out_instr1_o) && $stable(out_excp_o));

endmodule

// File: hw/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue
    import fetch_pkg::*;
#(
    parameter int FTQ_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush_i,
    input  logic        push_i,
    input  logic [31:0] push_va_i,
    input  logic [31:0] push_pa_i,
    input  fetch_excp_e push_excp_i,
    input  logic        pop_i,
    output logic        full_o,
    output logic        head_valid_o,
    output logic [31:0] head_va_o,
    output logic [31:0] head_pa_o,
    output fetch_excp_e head_excp_o
);

    localparam int PTR_W = $clog2(FTQ_DEPTH);

    logic [31:0]      va_mem   [FTQ_DEPTH];
    logic [31:0]      pa_mem   [FTQ_DEPTH];
    fetch_excp_e      excp_mem [FTQ_DEPTH];

    // Top bit is the wrap flag
    logic [PTR_W:0]   wr_ptr_q;
    logic [PTR_W:0]   rd_ptr_q;
    logic             push_fire;
    logic             pop_fire;

    assign full_o = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                    (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
    assign head_valid_o = (wr_ptr_q != rd_ptr_q);

    assign push_fire = push_i && !full_o;
    assign pop_fire  = pop_i && head_valid_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (flush_i) begin
            // Empty the queue at once
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            va_mem[wr_ptr_q[PTR_W-1:0]]   <= push_va_i;
            pa_mem[wr_ptr_q[PTR_W-1:0]]   <= push_pa_i;
            excp_mem[wr_ptr_q[PTR_W-1:0]] <= push_excp_i;
        end
    end

    assign head_va_o   = va_mem[rd_ptr_q[PTR_W-1:0]];
    assign head_pa_o   = pa_mem[rd_ptr_q[PTR_W-1:0]];
    assign head_excp_o = excp_mem[rd_ptr_q[PTR_W-1:0]];

    // Fetch unit only takes a head that is there
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> head_valid_o);

endmodule

// File: hw/pc_gen.sv
`timescale 1ns/1ps

module pc_gen
    import fetch_pkg::*;
    import csr_pkg::*;
#(
    parameter logic [31:0] RESET_PC = DEFAULT_RESET_PC
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush_i,
    input  logic [31:0] target_pc_i,
    input  logic        csr_da_i,
    input  logic [31:0] csr_dmw0_i,
    input  logic [31:0] csr_dmw1_i,
    input  plv_e        csr_plv_i,
    input  logic        full_i,
    output logic        push_o,
    output logic [31:0] push_va_o,
    output logic [31:0] push_pa_o,
    output fetch_excp_e push_excp_o
);

    logic [31:0] pc_q;
    logic [31:0] pc_d;
    logic        run_q;
    logic        dmw0_hit;
    logic        dmw1_hit;
    logic [31:0] trans_pa;

    // Window hit needs the enable bit of the current level and a matching segment
    function automatic logic dmw_match(
        input logic [31:0] dmw,
        input plv_e        plv,
        input logic [2:0]  vseg
    );
        logic plv_ok;
        plv_ok = (dmw[DMW_PLV0_BIT] && plv == PLV_KERNEL) ||
                 (dmw[DMW_PLV3_BIT] && plv == PLV_USER);
        return plv_ok && (dmw[DMW_VSEG_LSB +: 3] == vseg);
    endfunction

    // Stays low for the first cycle out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
            pc_q  <= RESET_PC;
        end else begin
            run_q <= 1'b1;
            pc_q  <= pc_d;
        end
    end

    assign push_o = run_q && !flush_i && !full_i;

    // Flush target first, then advance on an accepted push
    always_comb begin
        if (flush_i) begin
            pc_d = target_pc_i;
        end else if (push_o) begin
            pc_d = pc_q + BLOCK_BYTES;
        end else begin
            pc_d = pc_q;
        end
    end

    assign dmw0_hit = dmw_match(csr_dmw0_i, csr_plv_i, pc_q[31:29]);
    assign dmw1_hit = dmw_match(csr_dmw1_i, csr_plv_i, pc_q[31:29]);

    // DMW0 wins when both windows hit
    always_comb begin
        if (csr_da_i) begin
            trans_pa = pc_q;
        end else if (dmw0_hit) begin
            trans_pa = {csr_dmw0_i[DMW_PSEG_LSB +: 3], pc_q[28:0]};
        end else if (dmw1_hit) begin
            trans_pa = {csr_dmw1_i[DMW_PSEG_LSB +: 3], pc_q[28:0]};
        end else begin
            trans_pa = pc_q;
        end
    end

    always_comb begin
        if (pc_q[1:0] != 2'b00) begin
            push_excp_o = EXCP_ADEF;
        end else if (!csr_da_i && !dmw0_hit && !dmw1_hit) begin
            push_excp_o = EXCP_NOMAP;
        end else begin
            push_excp_o = EXCP_NONE;
        end
    end

    assign push_va_o = pc_q;
    assign push_pa_o = (push_excp_o == EXCP_NONE) ? trans_pa : pc_q;

endmodule

// File: hw/csr_pkg.sv
package csr_pkg;

    // Window enable per privilege level
    localparam int DMW_PLV0_BIT = 0;
    localparam int DMW_PLV3_BIT = 3;

    // Physical segment, bits 27:25
    localparam int DMW_PSEG_LSB = 25;

    // Virtual segment, bits 31:29
    localparam int DMW_VSEG_LSB = 29;

    typedef enum logic [1:0] {
        PLV_KERNEL = 2'd0,
        PLV_USER   = 2'd3
    } plv_e;

endpackage

// File: hw/fetch_pkg.sv
package fetch_pkg;

    // Instructions per fetch block
    localparam logic [31:0] FETCH_WORDS = 32'd2;

    // PC step from one block to the next
    localparam logic [31:0] BLOCK_BYTES = 32'd8;

    // Fetch exceptions, ADEF has priority over NOMAP
    typedef enum logic [1:0] {
        EXCP_NONE  = 2'd0,
        // PC not word aligned
        EXCP_ADEF  = 2'd1,
        // Translation enabled and no window hit
        EXCP_NOMAP = 2'd2
    } fetch_excp_e;

    // Boot address
    localparam logic [31:0] DEFAULT_RESET_PC = 32'h1c00_0000;

endpackage
